/* rtl/vdec_pkg.sv */
package vdec_pkg;

  // scalar operand and lane data width
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // same code as vsew in vtype[5:3]
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  typedef enum logic [2:0] {
    VALU_ADD       = 3'd0,
    VALU_SLIDEUP   = 3'd1,
    VALU_SLIDEDOWN = 3'd2,
    VALU_GATHER    = 3'd3,
    VALU_WADDU     = 3'd4,
    VALU_NSRL      = 3'd5
  } valu_op_t;

  // source element offset for vs2
  typedef enum logic [1:0] {
    VS2_SRC_NORMAL        = 2'd0,
    VS2_SRC_IDX_PLUS_RS1  = 2'd1,
    VS2_SRC_IDX_PLUS_UIMM = 2'd2,
    VS2_SRC_VS1           = 2'd3
  } vs2_src_t;

  // element offset for the vd write
  typedef enum logic [1:0] {
    VD_SRC_NORMAL        = 2'd0,
    VD_SRC_IDX_PLUS_RS1  = 2'd1,
    VD_SRC_IDX_PLUS_UIMM = 2'd2
  } vd_src_t;

  localparam logic [6:0] OPC_OPV  = 7'b1010111;
  localparam logic [2:0] F3_OPIVV = 3'b000;
  localparam logic [2:0] F3_OPMVV = 3'b010;
  localparam logic [2:0] F3_OPIVI = 3'b011;
  localparam logic [2:0] F3_OPIVX = 3'b100;

  localparam logic [5:0] F6_ADD       = 6'b000000;
  localparam logic [5:0] F6_RGATHER   = 6'b001100;
  localparam logic [5:0] F6_SLIDEUP   = 6'b001110;
  localparam logic [5:0] F6_SLIDEDOWN = 6'b001111;
  localparam logic [5:0] F6_NSRL      = 6'b101100;
  localparam logic [5:0] F6_WADDU     = 6'b110000;

endpackage

/* rtl/vdec_ctrl.sv */
`timescale 1ns/100ps

module vdec_ctrl #(
  parameter int OFFSET_W = 8
) (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            flush,
  input  logic                            instr_valid,
  input  logic                            instr_ready,
  input  logic [vdec_pkg::XLEN-1:0]       instr,
  input  logic [vdec_pkg::XLEN-1:0]       xs1,
  input  vdec_pkg::sew_t                  vtype_sew,
  input  logic [OFFSET_W-1:0]             vl,
  output vdec_pkg::valu_op_t              aluop,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vs1_idx,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vs2_idx,
  output logic [vdec_pkg::REG_ADDR_W-1:0] vd_idx,
  output logic [4:0]                      imm5,
  output logic                            vm,
  output vdec_pkg::vs2_src_t              vs2_src,
  output vdec_pkg::vd_src_t               vd_src,
  output logic                            widen,
  output logic                            narrow,
  output logic                            legal,
  output logic [vdec_pkg::XLEN-1:0]       held_xs1,
  output vdec_pkg::sew_t                  held_sew,
  output logic [OFFSET_W-1:0]             held_vl,
  output logic                            start
);
  import vdec_pkg::*;

  logic [XLEN-1:0] held_instr;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [5:0]      funct6;
  logic            accept;

  assign accept = instr_valid & instr_ready;

  // one-cycle pulse after the instruction is taken
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      start <= 1'b0;
    end else begin
      start <= accept & ~flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      held_instr <= instr;
      held_xs1   <= xs1;
      held_sew   <= vtype_sew;
      held_vl    <= vl;
    end
  end

  // OPV field layout
  assign opcode  = held_instr[6:0];
  assign vd_idx  = held_instr[11:7];
  assign funct3  = held_instr[14:12];
  assign vs1_idx = held_instr[19:15];
  assign imm5    = held_instr[19:15];
  assign vs2_idx = held_instr[24:20];
  assign vm      = held_instr[25];
  assign funct6  = held_instr[31:26];

  always_comb begin
    aluop   = VALU_ADD;
    vs2_src = VS2_SRC_NORMAL;
    vd_src  = VD_SRC_NORMAL;
    widen   = 1'b0;
    narrow  = 1'b0;
    legal   = 1'b0;
    if (opcode == OPC_OPV) begin
      case (funct6)
        F6_ADD: begin
          legal = (funct3 == F3_OPIVV) || (funct3 == F3_OPIVX) || (funct3 == F3_OPIVI);
        end
        F6_SLIDEUP: begin
          aluop  = VALU_SLIDEUP;
          vd_src = (funct3 == F3_OPIVX) ? VD_SRC_IDX_PLUS_RS1 : VD_SRC_IDX_PLUS_UIMM;
          legal  = (funct3 == F3_OPIVX) || (funct3 == F3_OPIVI);
        end
        F6_SLIDEDOWN: begin
          aluop   = VALU_SLIDEDOWN;
          vs2_src = (funct3 == F3_OPIVX) ? VS2_SRC_IDX_PLUS_RS1 : VS2_SRC_IDX_PLUS_UIMM;
          legal   = (funct3 == F3_OPIVX) || (funct3 == F3_OPIVI);
        end
        F6_RGATHER: begin
          // gather index comes from the vs1 element
          aluop   = VALU_GATHER;
          vs2_src = VS2_SRC_VS1;
          legal   = (funct3 == F3_OPIVV);
        end
        F6_WADDU: begin
          aluop = VALU_WADDU;
          widen = 1'b1;
          legal = (funct3 == F3_OPMVV);
        end
        F6_NSRL: begin
          aluop  = VALU_NSRL;
          narrow = 1'b1;
          legal  = (funct3 == F3_OPIVV);
        end
        default: begin
          legal = 1'b0;
        end
      endcase
    end
  end

endmodule

/* rtl/elem_counter.sv */
`timescale 1ns/100ps

module elem_counter #(
  parameter int OFFSET_W = 8
) (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                flush,
  input  logic                start,
  input  logic                legal,
  input  logic [OFFSET_W-1:0] vl,
  input  logic                advance,
  output logic [OFFSET_W-1:0] offset,
  output logic                busy,
  output logic                last
);

  logic                run_q;
  logic [OFFSET_W:0]   next_off;

  // extra bit so offset+2 never wraps in the compare
  assign next_off = {1'b0, offset} + 2'd2;
  assign last     = next_off >= {1'b0, vl};

  // the decode cycle after acceptance also counts as busy
  assign busy = run_q | start;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      run_q  <= 1'b0;
      offset <= '0;
    end else if (flush) begin
      run_q  <= 1'b0;
      offset <= '0;
    end else if (start) begin
      run_q  <= legal && (vl != '0);
      offset <= '0;
    end else if (run_q && advance) begin
      offset <= next_off[OFFSET_W-1:0];
      if (last) begin
        run_q <= 1'b0;
      end
    end
  end

endmodule

/* rtl/operand_offsets.sv */
`timescale 1ns/100ps

module operand_offsets #(
  parameter int OFFSET_W = 8
) (
  input  logic [OFFSET_W-1:0]       offset,
  input  vdec_pkg::vs2_src_t        vs2_src,
  input  vdec_pkg::vd_src_t         vd_src,
  input  logic [vdec_pkg::XLEN-1:0] xs1,
  input  logic [4:0]                imm5,
  input  logic [vdec_pkg::XLEN-1:0] rf_vs1_lane0,
  input  logic [vdec_pkg::XLEN-1:0] rf_vs1_lane1,
  input  vdec_pkg::sew_t            sew,
  input  logic                      widen,
  input  logic                      narrow,
  output logic [OFFSET_W-1:0]       vs2_offset0,
  output logic [OFFSET_W-1:0]       vs2_offset1,
  output logic [OFFSET_W-1:0]       woffset0,
  output logic [OFFSET_W-1:0]       woffset1,
  output vdec_pkg::sew_t            eew,
  output vdec_pkg::sew_t            vs2_sew
);
  import vdec_pkg::*;

  logic [OFFSET_W-1:0] rs1_off;
  logic [OFFSET_W-1:0] uimm_off;
  logic [OFFSET_W-1:0] vs2_base;
  logic [OFFSET_W-1:0] vd_base;

  // sums wrap at OFFSET_W
  assign rs1_off  = OFFSET_W'(xs1);
  assign uimm_off = OFFSET_W'(imm5);

  always_comb begin
    case (vs2_src)
      VS2_SRC_IDX_PLUS_RS1:  vs2_base = offset + rs1_off;
      VS2_SRC_IDX_PLUS_UIMM: vs2_base = offset + uimm_off;
      default:               vs2_base = offset;
    endcase
    if (vs2_src == VS2_SRC_VS1) begin
      vs2_offset0 = OFFSET_W'(rf_vs1_lane0);
      vs2_offset1 = OFFSET_W'(rf_vs1_lane1);
    end else begin
      vs2_offset0 = vs2_base;
      vs2_offset1 = vs2_base + 1'b1;
    end
  end

  always_comb begin
    case (vd_src)
      VD_SRC_IDX_PLUS_RS1:  vd_base = offset + rs1_off;
      VD_SRC_IDX_PLUS_UIMM: vd_base = offset + uimm_off;
      default:              vd_base = offset;
    endcase
    woffset0 = vd_base;
    woffset1 = vd_base + 1'b1;
  end

  // widen caps at SEW32, narrow floors at SEW8
  always_comb begin
    eew     = sew;
    vs2_sew = sew;
    if (widen) begin
      eew = (sew == SEW8) ? SEW16 : SEW32;
    end else if (narrow) begin
      eew     = (sew == SEW32) ? SEW16 : SEW8;
      vs2_sew = (sew == SEW8) ? SEW16 : SEW32;
    end
  end

endmodule

/* rtl/de_pipe_reg.sv */
`timescale 1ns/100ps

module de_pipe_reg #(
  parameter int OFFSET_W = 8
) (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            flush,
  input  logic                            busy,
  input  logic                            start,
  input  logic [OFFSET_W-1:0]             offset,
  input  logic [OFFSET_W-1:0]             vl,
  input  vdec_pkg::valu_op_t              aluop,
  input  logic [vdec_pkg::REG_ADDR_W-1:0] vd_idx,
  input  logic [4:0]                      imm5,
  input  logic                            vm,
  input  logic                            narrow,
  input  vdec_pkg::sew_t                  sew,
  input  vdec_pkg::sew_t                  eew,
  input  logic [OFFSET_W-1:0]             woffset0,
  input  logic [OFFSET_W-1:0]             woffset1,
  input  logic [OFFSET_W-1:0]             vs2_offset0,
  input  logic [OFFSET_W-1:0]             vs2_offset1,
  input  logic [vdec_pkg::XLEN-1:0]       rf_vs1_lane0,
  input  logic [vdec_pkg::XLEN-1:0]       rf_vs1_lane1,
  input  logic [vdec_pkg::XLEN-1:0]       rf_vs2_lane0,
  input  logic [vdec_pkg::XLEN-1:0]       rf_vs2_lane1,
  input  logic [1:0]                      rf_mask,
  input  logic                            out_ready,
  output logic                            advance,
  output logic                            out_valid,
  output vdec_pkg::valu_op_t              out_aluop,
  output vdec_pkg::sew_t                  out_eew,
  output logic [vdec_pkg::REG_ADDR_W-1:0] out_vd,
  output logic [OFFSET_W-1:0]             out_woffset0,
  output logic [OFFSET_W-1:0]             out_woffset1,
  output logic [1:0]                      out_wen,
  output logic [vdec_pkg::XLEN-1:0]       out_vs1_lane0,
  output logic [vdec_pkg::XLEN-1:0]       out_vs1_lane1,
  output logic [vdec_pkg::XLEN-1:0]       out_vs2_lane0,
  output logic [vdec_pkg::XLEN-1:0]       out_vs2_lane1,
  output logic [OFFSET_W-1:0]             out_vs2_offset0,
  output logic [OFFSET_W-1:0]             out_vs2_offset1,
  output logic [vdec_pkg::XLEN-1:0]       out_imm
);
  import vdec_pkg::*;

  logic       load;
  logic       lane1_active;
  logic [1:0] wen;

  // keep the narrowed source element only
  function automatic logic [XLEN-1:0] narrow_lane(input logic [XLEN-1:0] d,
                                                  input logic nar,
                                                  input sew_t s);
    narrow_lane = d;
    if (nar && (s == SEW32)) begin
      narrow_lane = {{(XLEN-16){1'b0}}, d[15:0]};
    end else if (nar && (s == SEW16)) begin
      narrow_lane = {{(XLEN-8){1'b0}}, d[7:0]};
    end
  endfunction

  assign advance = ~out_valid | out_ready;
  // no micro-op in the decode cycle that follows acceptance
  assign load    = advance & busy & ~start;

  // tail lane past vl
  assign lane1_active = ({1'b0, offset} + 1'b1) < {1'b0, vl};
  assign wen[0]       = vm | rf_mask[0];
  assign wen[1]       = (vm | rf_mask[1]) & lane1_active;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      out_wen   <= 2'b00;
    end else if (flush) begin
      out_valid <= 1'b0;
      out_wen   <= 2'b00;
    end else if (advance) begin
      out_valid <= load;
      out_wen   <= load ? wen : 2'b00;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      out_aluop       <= aluop;
      out_eew         <= eew;
      out_vd          <= vd_idx;
      out_woffset0    <= woffset0;
      out_woffset1    <= woffset1;
      out_vs1_lane0   <= rf_vs1_lane0;
      out_vs1_lane1   <= rf_vs1_lane1;
      out_vs2_lane0   <= narrow_lane(rf_vs2_lane0, narrow, sew);
      out_vs2_lane1   <= narrow_lane(rf_vs2_lane1, narrow, sew);
      out_vs2_offset0 <= vs2_offset0;
      out_vs2_offset1 <= vs2_offset1;
      out_imm         <= {{(XLEN-5){imm5[4]}}, imm5};
    end
  end

endmodule

/* rtl/vdecode_stage.sv */
`timescale 1ns/100ps

module vdecode_stage #(
  parameter int OFFSET_W = 8
) (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            flush,
  input  logic                            instr_valid,
  output logic                            instr_ready,
  input  logic [vdec_pkg::XLEN-1:0]       instr,
  input  logic [vdec_pkg::XLEN-1:0]       xs1,
  input  vdec_pkg::sew_t                  vtype_sew,
  input  logic [OFFSET_W-1:0]             vl,
  output logic [vdec_pkg::REG_ADDR_W-1:0] rf_vs1,
  output logic [vdec_pkg::REG_ADDR_W-1:0] rf_vs2,
  output logic [vdec_pkg::REG_ADDR_W-1:0] rf_vs3,
  output logic [OFFSET_W-1:0]             rf_vs1_offset,
  output logic [OFFSET_W-1:0]             rf_vs2_offset,
  output logic [OFFSET_W-1:0]             rf_vs3_offset,
  output vdec_pkg::sew_t                  rf_vs2_sew,
  input  logic [vdec_pkg::XLEN-1:0]       rf_vs1_lane0,
  input  logic [vdec_pkg::XLEN-1:0]       rf_vs1_lane1,
  input  logic [vdec_pkg::XLEN-1:0]       rf_vs2_lane0,
  input  logic [vdec_pkg::XLEN-1:0]       rf_vs2_lane1,
  input  logic [1:0]                      rf_mask,
  output logic                            out_valid,
  input  logic                            out_ready,
  output vdec_pkg::valu_op_t              out_aluop,
  output vdec_pkg::sew_t                  out_eew,
  output logic [vdec_pkg::REG_ADDR_W-1:0] out_vd,
  output logic [OFFSET_W-1:0]             out_woffset0,
  output logic [OFFSET_W-1:0]             out_woffset1,
  output logic [1:0]                      out_wen,
  output logic [vdec_pkg::XLEN-1:0]       out_vs1_lane0,
  output logic [vdec_pkg::XLEN-1:0]       out_vs1_lane1,
  output logic [vdec_pkg::XLEN-1:0]       out_vs2_lane0,
  output logic [vdec_pkg::XLEN-1:0]       out_vs2_lane1,
  output logic [OFFSET_W-1:0]             out_vs2_offset0,
  output logic [OFFSET_W-1:0]             out_vs2_offset1,
  output logic [vdec_pkg::XLEN-1:0]       out_imm
);
  import vdec_pkg::*;

  valu_op_t              aluop;
  vs2_src_t              vs2_src;
  vd_src_t               vd_src;
  sew_t                  held_sew;
  sew_t                  eew;
  logic [REG_ADDR_W-1:0] vd_idx;
  logic [4:0]            imm5;
  logic                  vm;
  logic                  widen;
  logic                  narrow;
  logic                  legal;
  logic                  start;
  logic [XLEN-1:0]       held_xs1;
  logic [OFFSET_W-1:0]   held_vl;
  logic [OFFSET_W-1:0]   offset;
  logic                  busy;
  logic                  last;
  logic                  advance;
  logic [OFFSET_W-1:0]   vs2_offset1;
  logic [OFFSET_W-1:0]   woffset1;

  assign instr_ready   = ~busy;
  assign rf_vs1_offset = offset;
  assign rf_vs3        = vd_idx;

  vdec_ctrl #(.OFFSET_W(OFFSET_W)) vdec_ctrl_i (
    .CLK, .nRST, .flush, .instr_valid, .instr_ready, .instr, .xs1, .vtype_sew, .vl,
    .aluop, .vs1_idx(rf_vs1), .vs2_idx(rf_vs2), .vd_idx, .imm5, .vm, .vs2_src,
    .vd_src, .widen, .narrow, .legal, .held_xs1, .held_sew, .held_vl, .start
  );

  // last only gates the counter's own busy drop
  elem_counter #(.OFFSET_W(OFFSET_W)) elem_counter_i (
    .CLK, .nRST, .flush, .start, .legal, .vl(held_vl), .advance,
    .offset, .busy, .last
  );

  operand_offsets #(.OFFSET_W(OFFSET_W)) operand_offsets_i (
    .offset, .vs2_src, .vd_src, .xs1(held_xs1), .imm5, .rf_vs1_lane0, .rf_vs1_lane1,
    .sew(held_sew), .widen, .narrow, .vs2_offset0(rf_vs2_offset), .vs2_offset1,
    .woffset0(rf_vs3_offset), .woffset1, .eew, .vs2_sew(rf_vs2_sew)
  );

  de_pipe_reg #(.OFFSET_W(OFFSET_W)) de_pipe_reg_i (
    .CLK, .nRST, .flush, .busy, .start, .offset, .vl(held_vl), .aluop, .vd_idx,
    .imm5, .vm, .narrow, .sew(held_sew), .eew, .woffset0(rf_vs3_offset), .woffset1,
    .vs2_offset0(rf_vs2_offset), .vs2_offset1, .rf_vs1_lane0, .rf_vs1_lane1,
    .rf_vs2_lane0, .rf_vs2_lane1, .rf_mask, .out_ready, .advance, .out_valid,
    .out_aluop, .out_eew, .out_vd, .out_woffset0, .out_woffset1, .out_wen,
    .out_vs1_lane0, .out_vs1_lane1, .out_vs2_lane0, .out_vs2_lane1,
    .out_vs2_offset0, .out_vs2_offset1, .out_imm
  );

endmodule

/* verif/vdecode_chk.sv */
`timescale 1ns/100ps

module vdecode_chk #(
  parameter int OFFSET_W = 8
) (
  input logic                CLK,
  input logic                nRST,
  input logic                flush,
  input logic                busy,
  input logic                instr_valid,
  input logic                instr_ready,
  input logic                out_valid,
  input logic                out_ready,
  input logic [2:0]          out_aluop,
  input logic [1:0]          out_eew,
  input logic [4:0]          out_vd,
  input logic [OFFSET_W-1:0] out_woffset0,
  input logic [OFFSET_W-1:0] out_woffset1,
  input logic [1:0]          out_wen,
  input logic [31:0]         out_vs1_lane0,
  input logic [31:0]         out_vs1_lane1,
  input logic [31:0]         out_vs2_lane0,
  input logic [31:0]         out_vs2_lane1,
  input logic [OFFSET_W-1:0] out_vs2_offset0,
  input logic [OFFSET_W-1:0] out_vs2_offset1,
  input logic [31:0]         out_imm
);

  int fail_cnt = 0;

  // stalled micro-op must hold
  assert property (@(posedge CLK) disable iff (!nRST)
    out_valid && !out_ready && !flush |=> out_valid && $stable({out_aluop, out_eew, out_vd,
      out_woffset0, out_woffset1, out_wen, out_vs1_lane0, out_vs1_lane1, out_vs2_lane0,
      out_vs2_lane1, out_vs2_offset0, out_vs2_offset1, out_imm}))
  else begin
    $error("stalled micro-op changed or vanished");
    fail_cnt++;
  end

  // decode cycle after acceptance holds off the next instruction
  assert property (@(posedge CLK) disable iff (!nRST)
    instr_valid && instr_ready && !flush |=> busy && !instr_ready)
  else begin
    $error("stage not busy in the cycle after an instruction was taken");
    fail_cnt++;
  end

  assert property (@(posedge CLK) disable iff (!nRST) !out_valid |-> out_wen == 2'b00)
  else begin
    $error("write enable set without a valid micro-op");
    fail_cnt++;
  end

endmodule

bind vdecode_stage vdecode_chk #(.OFFSET_W(OFFSET_W)) chk_i (
  .CLK, .nRST, .flush, .busy, .instr_valid, .instr_ready, .out_valid, .out_ready,
  .out_aluop, .out_eew, .out_vd, .out_woffset0, .out_woffset1, .out_wen, .out_vs1_lane0,
  .out_vs1_lane1, .out_vs2_lane0, .out_vs2_lane1, .out_vs2_offset0, .out_vs2_offset1,
  .out_imm
);

/* verif/vdecode_scoreboard.sv */
`timescale 1ns/100ps

module vdecode_scoreboard #(
  parameter int OFFSET_W = 8
) (
  input logic                            CLK,
  input logic                            nRST,
  input logic                            flush,
  input logic                            instr_valid,
  input logic                            instr_ready,
  input logic [vdec_pkg::XLEN-1:0]       instr,
  input logic [vdec_pkg::XLEN-1:0]       xs1,
  input vdec_pkg::sew_t                  vtype_sew,
  input logic [OFFSET_W-1:0]             vl,
  input logic [vdec_pkg::REG_ADDR_W-1:0] rf_vs3,
  input logic [OFFSET_W-1:0]             rf_vs3_offset,
  input vdec_pkg::sew_t                  rf_vs2_sew,
  input logic                            out_valid,
  input logic                            out_ready,
  input vdec_pkg::valu_op_t              out_aluop,
  input vdec_pkg::sew_t                  out_eew,
  input logic [vdec_pkg::REG_ADDR_W-1:0] out_vd,
  input logic [OFFSET_W-1:0]             out_woffset0,
  input logic [OFFSET_W-1:0]             out_woffset1,
  input logic [1:0]                      out_wen,
  input logic [vdec_pkg::XLEN-1:0]       out_vs1_lane0,
  input logic [vdec_pkg::XLEN-1:0]       out_vs1_lane1,
  input logic [vdec_pkg::XLEN-1:0]       out_vs2_lane0,
  input logic [vdec_pkg::XLEN-1:0]       out_vs2_lane1,
  input logic [OFFSET_W-1:0]             out_vs2_offset0,
  input logic [OFFSET_W-1:0]             out_vs2_offset1,
  input logic [vdec_pkg::XLEN-1:0]       out_imm
);
  import vdec_pkg::*;

  typedef struct packed {
    logic [2:0]          aluop;
    logic [1:0]          eew;
    logic [1:0]          vs2sew;
    logic [4:0]          vd;
    logic [OFFSET_W-1:0] woff0;
    logic [OFFSET_W-1:0] woff1;
    logic [1:0]          wen;
    logic [31:0]         v1l0;
    logic [31:0]         v1l1;
    logic [31:0]         v2l0;
    logic [31:0]         v2l1;
    logic [OFFSET_W-1:0] v2o0;
    logic [OFFSET_W-1:0] v2o1;
    logic [31:0]         imm;
  } uop_t;

  uop_t                exp_q[$];
  int                  mismatch_cnt = 0;
  int                  other_cnt    = 0;
  logic [4:0]          cap_vs3;
  logic [OFFSET_W-1:0] cap_vs3_off;
  logic [1:0]          cap_vs2_sew;

  function automatic logic [31:0] elem_val(input logic [4:0] idx,
                                           input logic [OFFSET_W-1:0] off);
    elem_val = (32'(idx) << 8) + 32'(off);
  endfunction

  function automatic logic mask_bit(input logic [OFFSET_W-1:0] off);
    mask_bit = off[1] ^ off[0];
  endfunction

  // expected micro-ops of one accepted instruction
  task automatic push_expected(input logic [31:0] ins, input logic [31:0] x1,
                               input sew_t s, input logic [OFFSET_W-1:0] n);
    uop_t                u;
    logic [2:0]          f3;
    logic [5:0]          f6;
    logic [4:0]          imm;
    logic [31:0]         vd_add;
    logic [31:0]         vs2_add;
    logic [OFFSET_W-1:0] o0;
    logic [OFFSET_W-1:0] o1;
    logic [OFFSET_W-1:0] p1;
    bit                  ok;
    bit                  gather;
    bit                  widen;
    bit                  narrow;
    f3      = ins[14:12];
    f6      = ins[31:26];
    imm     = ins[19:15];
    ok      = 1'b0;
    gather  = 1'b0;
    widen   = 1'b0;
    narrow  = 1'b0;
    vd_add  = '0;
    vs2_add = '0;
    u       = '0;
    if (ins[6:0] == OPC_OPV) begin
      if (f6 == F6_ADD) begin
        ok = (f3 == F3_OPIVV) || (f3 == F3_OPIVX) || (f3 == F3_OPIVI);
        u.aluop = VALU_ADD;
      end else if (f6 == F6_SLIDEUP || f6 == F6_SLIDEDOWN) begin
        ok = (f3 == F3_OPIVX) || (f3 == F3_OPIVI);
        u.aluop = (f6 == F6_SLIDEUP) ? VALU_SLIDEUP : VALU_SLIDEDOWN;
        if (f6 == F6_SLIDEUP) begin
          vd_add = (f3 == F3_OPIVX) ? x1 : 32'(imm);
        end else begin
          vs2_add = (f3 == F3_OPIVX) ? x1 : 32'(imm);
        end
      end else if (f6 == F6_RGATHER) begin
        ok = (f3 == F3_OPIVV);
        u.aluop = VALU_GATHER;
        gather = 1'b1;
      end else if (f6 == F6_WADDU) begin
        ok = (f3 == F3_OPMVV);
        u.aluop = VALU_WADDU;
        widen = 1'b1;
      end else if (f6 == F6_NSRL) begin
        ok = (f3 == F3_OPIVV);
        u.aluop = VALU_NSRL;
        narrow = 1'b1;
      end
    end
    // one code step doubles or halves the width
    u.eew    = s;
    u.vs2sew = s;
    if (widen) begin
      u.eew = (s == SEW32) ? SEW32 : s + 2'd1;
    end else if (narrow) begin
      u.eew    = (s == SEW8) ? SEW8 : s - 2'd1;
      u.vs2sew = (s == SEW32) ? SEW32 : s + 2'd1;
    end
    u.vd  = ins[11:7];
    u.imm = {{27{imm[4]}}, imm};
    for (int o = 0; ok && o < int'(n); o += 2) begin
      o0     = OFFSET_W'(o);
      o1     = OFFSET_W'(o + 1);
      u.woff0 = OFFSET_W'(32'(o) + vd_add);
      u.woff1 = OFFSET_W'(32'(o) + vd_add + 32'd1);
      u.v1l0  = elem_val(ins[19:15], o0);
      u.v1l1  = elem_val(ins[19:15], o1);
      u.v2o0  = gather ? OFFSET_W'(u.v1l0) : OFFSET_W'(32'(o) + vs2_add);
      u.v2o1  = gather ? OFFSET_W'(u.v1l1) : OFFSET_W'(32'(o) + vs2_add + 32'd1);
      p1      = u.v2o0 + 1'b1;
      u.v2l0  = elem_val(ins[24:20], u.v2o0);
      u.v2l1  = elem_val(ins[24:20], p1);
      if (narrow && s == SEW32) begin
        u.v2l0 &= 32'h0000_ffff;
        u.v2l1 &= 32'h0000_ffff;
      end else if (narrow && s == SEW16) begin
        u.v2l0 &= 32'h0000_00ff;
        u.v2l1 &= 32'h0000_00ff;
      end
      u.wen[0] = ins[25] | mask_bit(o0);
      u.wen[1] = (ins[25] | mask_bit(o1)) & (o + 1 < int'(n));
      exp_q.push_back(u);
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Mismatch %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      mismatch_cnt++;
    end
  endtask

  task automatic compare_uop(input uop_t e);
    check_field("out_aluop", 32'(e.aluop), 32'(out_aluop));
    check_field("out_eew", 32'(e.eew), 32'(out_eew));
    check_field("out_vd", 32'(e.vd), 32'(out_vd));
    check_field("out_woffset0", 32'(e.woff0), 32'(out_woffset0));
    check_field("out_woffset1", 32'(e.woff1), 32'(out_woffset1));
    check_field("out_wen", 32'(e.wen), 32'(out_wen));
    check_field("out_vs1_lane0", e.v1l0, out_vs1_lane0);
    check_field("out_vs1_lane1", e.v1l1, out_vs1_lane1);
    check_field("out_vs2_lane0", e.v2l0, out_vs2_lane0);
    check_field("out_vs2_lane1", e.v2l1, out_vs2_lane1);
    check_field("out_vs2_offset0", 32'(e.v2o0), 32'(out_vs2_offset0));
    check_field("out_vs2_offset1", 32'(e.v2o1), 32'(out_vs2_offset1));
    check_field("out_imm", e.imm, out_imm);
    check_field("rf_vs3", 32'(e.vd), 32'(cap_vs3));
    check_field("rf_vs3_offset", 32'(e.woff0), 32'(cap_vs3_off));
    check_field("rf_vs2_sew", 32'(e.vs2sew), 32'(cap_vs2_sew));
  endtask

  task automatic report_leftover();
    if (exp_q.size() != 0) begin
      $display("%0d expected micro-ops never came out of the DUT", exp_q.size());
      other_cnt++;
    end
  endtask

  // flush drops everything in flight including an instruction taken on that edge
  always @(posedge CLK) begin
    if (!nRST || flush) begin
      exp_q.delete();
    end else begin
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected micro-op at %0t with no instruction pending", $time);
          other_cnt++;
        end else begin
          compare_uop(exp_q.pop_front());
        end
      end
      if (instr_valid && instr_ready) begin
        push_expected(instr, xs1, vtype_sew, vl);
      end
    end
    // register-file request seen on an edge where the output register can load
    if (!out_valid || out_ready) begin
      cap_vs3     = rf_vs3;
      cap_vs3_off = rf_vs3_offset;
      cap_vs2_sew = rf_vs2_sew;
    end
  end

endmodule

/* verif/tb_vdecode.sv */
`timescale 1ns/100ps

module tb_vdecode #(
  parameter int SEED = 63
);
  import vdec_pkg::*;

  localparam int OFFSET_W   = 10;
  localparam int NUM_INSTR  = 300;
  localparam int MAX_CYCLES = NUM_INSTR * 14 + 8;

  logic                  CLK;
  logic                  nRST;
  logic                  flush;
  logic                  instr_valid;
  logic                  instr_ready;
  logic [XLEN-1:0]       instr;
  logic [XLEN-1:0]       xs1;
  sew_t                  vtype_sew;
  logic [OFFSET_W-1:0]   vl;
  logic [REG_ADDR_W-1:0] rf_vs1;
  logic [REG_ADDR_W-1:0] rf_vs2;
  logic [REG_ADDR_W-1:0] rf_vs3;
  logic [OFFSET_W-1:0]   rf_vs1_offset;
  logic [OFFSET_W-1:0]   rf_vs2_offset;
  logic [OFFSET_W-1:0]   rf_vs3_offset;
  sew_t                  rf_vs2_sew;
  logic [XLEN-1:0]       rf_vs1_lane0;
  logic [XLEN-1:0]       rf_vs1_lane1;
  logic [XLEN-1:0]       rf_vs2_lane0;
  logic [XLEN-1:0]       rf_vs2_lane1;
  logic [1:0]            rf_mask;
  logic                  out_valid;
  logic                  out_ready;
  valu_op_t              out_aluop;
  sew_t                  out_eew;
  logic [REG_ADDR_W-1:0] out_vd;
  logic [OFFSET_W-1:0]   out_woffset0;
  logic [OFFSET_W-1:0]   out_woffset1;
  logic [1:0]            out_wen;
  logic [XLEN-1:0]       out_vs1_lane0;
  logic [XLEN-1:0]       out_vs1_lane1;
  logic [XLEN-1:0]       out_vs2_lane0;
  logic [XLEN-1:0]       out_vs2_lane1;
  logic [OFFSET_W-1:0]   out_vs2_offset0;
  logic [OFFSET_W-1:0]   out_vs2_offset1;
  logic [XLEN-1:0]       out_imm;
  logic [OFFSET_W-1:0]   vs1_off_p1;
  logic [OFFSET_W-1:0]   vs2_off_p1;
  int                    seed;
  int                    cycle_cnt;
  int                    sent;
  int                    flushes;
  bit                    have_instr;

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  vdecode_stage #(.OFFSET_W(OFFSET_W)) vdecode_stage_i (.*);

  vdecode_scoreboard #(.OFFSET_W(OFFSET_W)) sb_i (.*);

  // element value is index*256 + offset and the v0 bit is off[1]^off[0]
  function automatic logic [XLEN-1:0] elem_val(input logic [REG_ADDR_W-1:0] idx,
                                               input logic [OFFSET_W-1:0] off);
    elem_val = (XLEN'(idx) << 8) + XLEN'(off);
  endfunction

  assign vs1_off_p1   = rf_vs1_offset + 1'b1;
  assign vs2_off_p1   = rf_vs2_offset + 1'b1;
  assign rf_vs1_lane0 = elem_val(rf_vs1, rf_vs1_offset);
  assign rf_vs1_lane1 = elem_val(rf_vs1, vs1_off_p1);
  assign rf_vs2_lane0 = elem_val(rf_vs2, rf_vs2_offset);
  assign rf_vs2_lane1 = elem_val(rf_vs2, vs2_off_p1);
  assign rf_mask      = {vs1_off_p1[1] ^ vs1_off_p1[0], rf_vs1_offset[1] ^ rf_vs1_offset[0]};

  function automatic int urand(input int range);
    urand = int'($unsigned($random(seed)) % range);
  endfunction

  // random kept op or an illegal encoding for selections 10 and 11
  task automatic make_instr();
    logic [5:0] f6;
    logic [2:0] f3;
    int         sel;
    sel = urand(12);
    f6  = F6_ADD;
    f3  = F3_OPIVV;
    case (sel)
      1: f3 = F3_OPIVX;
      2: f3 = F3_OPIVI;
      3: begin
        f6 = F6_SLIDEUP;
        f3 = F3_OPIVX;
      end
      4: begin
        f6 = F6_SLIDEUP;
        f3 = F3_OPIVI;
      end
      5: begin
        f6 = F6_SLIDEDOWN;
        f3 = F3_OPIVX;
      end
      6: begin
        f6 = F6_SLIDEDOWN;
        f3 = F3_OPIVI;
      end
      7: f6 = F6_RGATHER;
      8: begin
        f6 = F6_WADDU;
        f3 = F3_OPMVV;
      end
      9: f6 = F6_NSRL;
      10: f6 = F6_SLIDEUP;
      default: f6 = F6_ADD;
    endcase
    instr        = $random(seed);
    instr[31:26] = f6;
    instr[14:12] = f3;
    instr[6:0]   = (sel == 11) ? 7'h33 : OPC_OPV;
    xs1          = $random(seed);
    vtype_sew    = sew_t'(urand(3));
    vl           = OFFSET_W'(urand(21));
  endtask

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    seed        = SEED;
    cycle_cnt   = 0;
    sent        = 0;
    flushes     = 0;
    have_instr  = 1'b0;
    nRST        = 1'b0;
    flush       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    xs1         = '0;
    vtype_sew   = SEW8;
    vl          = '0;
    out_ready   = 1'b0;
    repeat (8) @(posedge CLK);
    #2 nRST = 1'b1;
    while (sent < NUM_INSTR) begin
      @(posedge CLK);
      if (instr_valid && instr_ready) begin
        sent++;
        have_instr = 1'b0;
      end
      #2;
      flush     = 1'b0;
      out_ready = urand(10) >= 3;
      // two flushes in the middle of a walk
      if (flushes < 2 && sent >= 100 * (flushes + 1) && !instr_ready) begin
        flush = 1'b1;
        flushes++;
      end
      if (!have_instr) begin
        instr_valid = 1'b0;
        if (sent < NUM_INSTR && urand(4) != 0) begin
          make_instr();
          have_instr  = 1'b1;
          instr_valid = 1'b1;
        end
      end
    end
    out_ready = 1'b1;
    do begin
      @(posedge CLK);
    end while (!(instr_ready && !out_valid));
    sb_i.report_leftover();
    $display("Error counts: %0d mismatches, %0d other errors, %0d assertion failures",
             sb_i.mismatch_cnt, sb_i.other_cnt, vdecode_stage_i.chk_i.fail_cnt);
    if (sb_i.mismatch_cnt + sb_i.other_cnt + vdecode_stage_i.chk_i.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* flist.f */
rtl/vdec_pkg.sv
rtl/vdec_ctrl.sv
rtl/elem_counter.sv
rtl/operand_offsets.sv
rtl/de_pipe_reg.sv
rtl/vdecode_stage.sv
verif/vdecode_chk.sv
verif/vdecode_scoreboard.sv
verif/tb_vdecode.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_vdecode
SEED      ?= 63
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
